// File: Bender.yml
package:
  name: riscv_core

sources:
  - hdl/riscv_pkg.sv
  - hdl/fetch_pc.sv
  - hdl/inst_decoder.sv
  - hdl/reg_file.sv
  - hdl/stage_reg.sv
  - hdl/exec_alu.sv
  - hdl/mem_access_fsm.sv
  - hdl/hazard_ctrl.sv
  - hdl/riscv_core.sv
  - target: simulation
    include_dirs:
      - verif
    files:
      - verif/tb_riscv_core.sv

// File: hdl/exec_alu.sv
`timescale 1ns/1ps

module exec_alu (
    input riscv_pkg::word_t pc,
    input riscv_pkg::word_t a,
    input riscv_pkg::word_t b,
    input riscv_pkg::word_t imm,
    input riscv_pkg::alu_op_t alu_op,
    input logic use_imm,
    input logic is_branch,
    input logic is_jal,
    input logic valid,
    input logic [1:0] branch_cond,
    output riscv_pkg::word_t result,
    output riscv_pkg::word_t target,
    output logic taken
);

    riscv_pkg::word_t op_b;
    riscv_pkg::word_t alu_out;
    logic cond_met;

    assign op_b = use_imm ? imm : b;

    always_comb begin
        case (alu_op)
            riscv_pkg::alu_add: alu_out = a + op_b;
            riscv_pkg::alu_sub: alu_out = a - op_b;
            riscv_pkg::alu_and: alu_out = a & op_b;
            riscv_pkg::alu_or: alu_out = a | op_b;
            riscv_pkg::alu_xor: alu_out = a ^ op_b;
            riscv_pkg::alu_slt: alu_out = {31'd0, $signed(a) < $signed(op_b)};
            riscv_pkg::alu_sll: alu_out = a << op_b[4:0];
            riscv_pkg::alu_srl: alu_out = a >> op_b[4:0];
            riscv_pkg::alu_pass_b: alu_out = op_b;
            default: alu_out = '0;
        endcase
    end

    // branches compare the two register values
    always_comb begin
        case (branch_cond)
            riscv_pkg::br_eq: cond_met = (a == b);
            riscv_pkg::br_ne: cond_met = (a != b);
            riscv_pkg::br_lt: cond_met = ($signed(a) < $signed(b));
            default: cond_met = 1'b0;
        endcase
    end

    // link address for jal
    assign result = is_jal ? pc + 32'd4 : alu_out;
    assign target = pc + imm;
    assign taken = valid && (is_jal || (is_branch && cond_met));

endmodule

// File: hdl/fetch_pc.sv
`timescale 1ns/1ps

module fetch_pc (
    input logic clk,
    input logic rst,
    input logic stall,
    input logic redirect,
    input riscv_pkg::word_t target,
    output riscv_pkg::word_t pc
);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            pc <= riscv_pkg::reset_pc;
        end else if (redirect) begin
            pc <= target;
        end else if (!stall) begin
            pc <= pc + 32'd4;
        end
    end

    // a branch in execute is never a memory op, so both cannot meet
    a_no_redirect_in_stall: assert property (
        @(posedge clk) disable iff (!rst)
        !(redirect && stall)
    );

endmodule

// File: hdl/hazard_ctrl.sv
`timescale 1ns/1ps

module hazard_ctrl (
    input logic clk,
    input logic rst,
    input riscv_pkg::reg_addr_t rs1,
    input riscv_pkg::reg_addr_t rs2,
    input riscv_pkg::word_t rf_rs1,
    input riscv_pkg::word_t rf_rs2,
    input riscv_pkg::reg_addr_t ex_rd,
    input logic ex_writes,
    input riscv_pkg::word_t ex_value,
    input logic mem_busy,
    input logic taken,
    output riscv_pkg::word_t op_a,
    output riscv_pkg::word_t op_b,
    output riscv_pkg::reg_addr_t wb_addr,
    output logic wb_en,
    output riscv_pkg::word_t wb_data,
    output logic stall,
    output logic flush
);

    logic ex_hit_a;
    logic ex_hit_b;
    logic wb_hit_a;
    logic wb_hit_b;
    logic wb_load;

    // x0 never matches
    assign ex_hit_a = ex_writes && (ex_rd != '0) && (ex_rd == rs1);
    assign ex_hit_b = ex_writes && (ex_rd != '0) && (ex_rd == rs2);
    assign wb_hit_a = wb_en && (wb_addr != '0) && (wb_addr == rs1);
    assign wb_hit_b = wb_en && (wb_addr != '0) && (wb_addr == rs2);

    // newest value wins
    assign op_a = ex_hit_a ? ex_value : (wb_hit_a ? wb_data : rf_rs1);
    assign op_b = ex_hit_b ? ex_value : (wb_hit_b ? wb_data : rf_rs2);

    assign wb_load = ex_writes && !mem_busy;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wb_en <= 1'b0;
        end else begin
            wb_en <= wb_load;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_load) begin
            wb_addr <= ex_rd;
            wb_data <= ex_value;
        end
    end

    assign stall = mem_busy;
    assign flush = taken;

endmodule

// File: hdl/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
    input riscv_pkg::word_t inst,
    output riscv_pkg::reg_addr_t rs1,
    output riscv_pkg::reg_addr_t rs2,
    output riscv_pkg::reg_addr_t rd,
    output riscv_pkg::word_t imm,
    output riscv_pkg::alu_op_t alu_op,
    output logic use_imm,
    output logic is_load,
    output logic is_store,
    output logic is_branch,
    output logic is_jal,
    output logic writes_rd,
    output logic [1:0] branch_cond
);

    logic [6:0] opcode;
    logic [2:0] funct3;

    function automatic riscv_pkg::alu_op_t alu_from_f3(logic [2:0] f3, logic sub);
        case (f3)
            3'b000: return sub ? riscv_pkg::alu_sub : riscv_pkg::alu_add;
            3'b111: return riscv_pkg::alu_and;
            3'b110: return riscv_pkg::alu_or;
            3'b100: return riscv_pkg::alu_xor;
            3'b010: return riscv_pkg::alu_slt;
            3'b001: return riscv_pkg::alu_sll;
            3'b101: return riscv_pkg::alu_srl;
            default: return riscv_pkg::alu_add;
        endcase
    endfunction

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign rs1 = inst[19:15];
    assign rs2 = inst[24:20];
    assign rd = inst[11:7];

    always_comb begin
        imm = {{20{inst[31]}}, inst[31:20]};
        alu_op = riscv_pkg::alu_add;
        use_imm = 1'b0;
        is_load = 1'b0;
        is_store = 1'b0;
        is_branch = 1'b0;
        is_jal = 1'b0;
        writes_rd = 1'b0;
        branch_cond = riscv_pkg::br_eq;
        case (opcode)
            riscv_pkg::op_alu_r: begin
                alu_op = alu_from_f3(funct3, inst[30]);
                writes_rd = 1'b1;
            end
            riscv_pkg::op_alu_i: begin
                alu_op = alu_from_f3(funct3, 1'b0);
                use_imm = 1'b1;
                writes_rd = 1'b1;
            end
            riscv_pkg::op_lui: begin
                imm = {inst[31:12], 12'd0};
                alu_op = riscv_pkg::alu_pass_b;
                use_imm = 1'b1;
                writes_rd = 1'b1;
            end
            riscv_pkg::op_load: begin
                use_imm = 1'b1;
                is_load = 1'b1;
                writes_rd = 1'b1;
            end
            riscv_pkg::op_store: begin
                imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
                use_imm = 1'b1;
                is_store = 1'b1;
            end
            riscv_pkg::op_branch: begin
                imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
                // only beq, bne and blt are recognized
                is_branch = (funct3 == 3'b000) || (funct3 == 3'b001) || (funct3 == 3'b100);
                branch_cond = (funct3 == 3'b100) ? riscv_pkg::br_lt :
                              (funct3 == 3'b001) ? riscv_pkg::br_ne : riscv_pkg::br_eq;
            end
            riscv_pkg::op_jal: begin
                imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
                is_jal = 1'b1;
                writes_rd = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// File: hdl/mem_access_fsm.sv
`timescale 1ns/1ps

module mem_access_fsm (
    input logic clk,
    input logic rst,
    input logic start_load,
    input logic start_store,
    input riscv_pkg::word_t addr,
    input riscv_pkg::word_t store_data,
    input riscv_pkg::word_t rdata,
    input logic mem_ready,
    output logic read_en,
    output logic write_en,
    output logic busy,
    output riscv_pkg::word_t mem_addr,
    output riscv_pkg::word_t wdata,
    output riscv_pkg::word_t load_data
);

    riscv_pkg::mem_state_t state;
    logic rd_q;
    logic wr_q;
    riscv_pkg::word_t addr_q;
    riscv_pkg::word_t data_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= riscv_pkg::mem_idle;
            rd_q <= 1'b0;
            wr_q <= 1'b0;
        end else begin
            case (state)
                riscv_pkg::mem_idle: begin
                    if ((start_load || start_store) && !mem_ready) begin
                        state <= riscv_pkg::mem_wait;
                        rd_q <= start_load;
                        wr_q <= start_store;
                    end
                end
                riscv_pkg::mem_wait: begin
                    if (mem_ready) begin
                        state <= riscv_pkg::mem_idle;
                    end
                end
                default: state <= riscv_pkg::mem_idle;
            endcase
        end
    end

    // request copy held across the wait
    always_ff @(posedge clk) begin
        if (state == riscv_pkg::mem_idle) begin
            addr_q <= addr;
            data_q <= store_data;
        end
    end

    always_comb begin
        if (state == riscv_pkg::mem_wait) begin
            read_en = rd_q;
            write_en = wr_q;
            mem_addr = addr_q;
            wdata = data_q;
        end else begin
            read_en = start_load;
            write_en = start_store;
            mem_addr = addr;
            wdata = store_data;
        end
    end

    assign busy = (read_en || write_en) && !mem_ready;
    assign load_data = rdata;

    a_req_stable: assert property (
        @(posedge clk) disable iff (!rst)
        (read_en || write_en) && !mem_ready |=>
            $stable(mem_addr) && $stable(wdata) && $stable(read_en) && $stable(write_en)
    );

    // decode never flags an instruction as both load and store
    a_one_dir: assert property (
        @(posedge clk) disable iff (!rst)
        !(read_en && write_en)
    );

endmodule

// File: hdl/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input logic clk,
    input logic rst,
    input riscv_pkg::reg_addr_t rs1,
    input riscv_pkg::reg_addr_t rs2,
    input riscv_pkg::reg_addr_t wr_addr,
    input logic wr_en,
    input riscv_pkg::word_t wr_data,
    output riscv_pkg::word_t rs1_data,
    output riscv_pkg::word_t rs2_data
);

    // x0 has no storage
    riscv_pkg::word_t regs [1:31];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: hdl/riscv_core.sv
`timescale 1ns/1ps

module riscv_core (
    input logic clk,
    input logic rst,
    output riscv_pkg::word_t inst_addr,
    input riscv_pkg::word_t inst_data,
    output riscv_pkg::word_t mem_addr,
    output riscv_pkg::word_t wdata,
    output logic read_en,
    output logic write_en,
    input riscv_pkg::word_t rdata,
    input logic mem_ready
);

    riscv_pkg::if_id_t if_id_d;
    riscv_pkg::if_id_t if_id_q;
    riscv_pkg::id_ex_t id_ex_d;
    riscv_pkg::id_ex_t id_ex_q;

    riscv_pkg::reg_addr_t rs1;
    riscv_pkg::reg_addr_t rs2;
    riscv_pkg::word_t rf_rs1;
    riscv_pkg::word_t rf_rs2;
    riscv_pkg::reg_addr_t wb_addr;
    riscv_pkg::word_t wb_data;
    logic wb_en;

    riscv_pkg::word_t ex_result;
    riscv_pkg::word_t ex_target;
    riscv_pkg::word_t ex_value;
    riscv_pkg::word_t load_data;
    logic taken;
    logic mem_busy;
    logic stall;
    logic flush;

    fetch_pc u_fetch_pc (
        .clk(clk), .rst(rst), .stall(stall), .redirect(taken),
        .target(ex_target), .pc(inst_addr)
    );

    // fetch always delivers a valid word
    assign if_id_d = '{valid: 1'b1, pc: inst_addr, inst: inst_data};

    stage_reg #(.payload_t(riscv_pkg::if_id_t)) u_if_id (
        .clk(clk), .rst(rst), .hold(stall), .flush(flush), .d(if_id_d), .q(if_id_q)
    );

    inst_decoder u_inst_decoder (
        .inst(if_id_q.inst), .rs1(rs1), .rs2(rs2), .rd(id_ex_d.rd), .imm(id_ex_d.imm),
        .alu_op(id_ex_d.alu_op), .use_imm(id_ex_d.use_imm), .is_load(id_ex_d.is_load),
        .is_store(id_ex_d.is_store), .is_branch(id_ex_d.is_branch), .is_jal(id_ex_d.is_jal),
        .writes_rd(id_ex_d.writes_rd), .branch_cond(id_ex_d.branch_cond)
    );

    reg_file u_reg_file (
        .clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2), .wr_addr(wb_addr), .wr_en(wb_en),
        .wr_data(wb_data), .rs1_data(rf_rs1), .rs2_data(rf_rs2)
    );

    hazard_ctrl u_hazard_ctrl (
        .clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2), .rf_rs1(rf_rs1), .rf_rs2(rf_rs2),
        .ex_rd(id_ex_q.rd), .ex_writes(id_ex_q.valid && id_ex_q.writes_rd),
        .ex_value(ex_value), .mem_busy(mem_busy), .taken(taken),
        .op_a(id_ex_d.rs1_val), .op_b(id_ex_d.rs2_val), .wb_addr(wb_addr), .wb_en(wb_en),
        .wb_data(wb_data), .stall(stall), .flush(flush)
    );

    assign id_ex_d.valid = if_id_q.valid;
    assign id_ex_d.pc = if_id_q.pc;

    stage_reg #(.payload_t(riscv_pkg::id_ex_t)) u_id_ex (
        .clk(clk), .rst(rst), .hold(stall), .flush(flush), .d(id_ex_d), .q(id_ex_q)
    );

    exec_alu u_exec_alu (
        .pc(id_ex_q.pc), .a(id_ex_q.rs1_val), .b(id_ex_q.rs2_val), .imm(id_ex_q.imm),
        .alu_op(id_ex_q.alu_op), .use_imm(id_ex_q.use_imm), .is_branch(id_ex_q.is_branch),
        .is_jal(id_ex_q.is_jal), .valid(id_ex_q.valid), .branch_cond(id_ex_q.branch_cond),
        .result(ex_result), .target(ex_target), .taken(taken)
    );

    mem_access_fsm u_mem_access_fsm (
        .clk(clk), .rst(rst), .start_load(id_ex_q.valid && id_ex_q.is_load),
        .start_store(id_ex_q.valid && id_ex_q.is_store), .addr(ex_result),
        .store_data(id_ex_q.rs2_val), .rdata(rdata), .mem_ready(mem_ready),
        .read_en(read_en), .write_en(write_en), .busy(mem_busy), .mem_addr(mem_addr),
        .wdata(wdata), .load_data(load_data)
    );

    // load data replaces the address on completion
    assign ex_value = id_ex_q.is_load ? load_data : ex_result;

endmodule

// File: hdl/riscv_pkg.sv
package riscv_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_w = 5;

    typedef logic [xlen-1:0] word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    // major opcodes of the supported subset
    localparam logic [6:0] op_alu_r = 7'b0110011;
    localparam logic [6:0] op_alu_i = 7'b0010011;
    localparam logic [6:0] op_lui = 7'b0110111;
    localparam logic [6:0] op_load = 7'b0000011;
    localparam logic [6:0] op_store = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal = 7'b1101111;

    // branch condition codes
    localparam logic [1:0] br_eq = 2'd0;
    localparam logic [1:0] br_ne = 2'd1;
    localparam logic [1:0] br_lt = 2'd2;

    localparam word_t reset_pc = 32'h0000_0000;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sll,
        alu_srl,
        alu_pass_b
    } alu_op_t;

    typedef struct packed {
        logic valid;
        word_t pc;
        word_t inst;
    } if_id_t;

    typedef struct packed {
        logic valid;
        word_t pc;
        word_t rs1_val;
        word_t rs2_val;
        word_t imm;
        reg_addr_t rd;
        alu_op_t alu_op;
        logic use_imm;
        logic is_load;
        logic is_store;
        logic is_branch;
        logic is_jal;
        logic writes_rd;
        logic [1:0] branch_cond;
    } id_ex_t;

    typedef enum logic {
        mem_idle,
        mem_wait
    } mem_state_t;

endpackage

// File: hdl/stage_reg.sv
`timescale 1ns/1ps

module stage_reg #(
    parameter type payload_t = logic
) (
    input logic clk,
    input logic rst,
    input logic hold,
    input logic flush,
    input payload_t d,
    output payload_t q
);

    // cleared payload has valid low
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            q <= '0;
        end else if (flush) begin
            q <= '0;
        end else if (!hold) begin
            q <= d;
        end
    end

endmodule

// File: riscv_core.f
+incdir+verif
hdl/riscv_pkg.sv
hdl/fetch_pc.sv
hdl/inst_decoder.sv
hdl/reg_file.sv
hdl/stage_reg.sv
hdl/exec_alu.sv
hdl/mem_access_fsm.sv
hdl/hazard_ctrl.sv
hdl/riscv_core.sv
verif/tb_riscv_core.sv

// File: verif/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// program words at consecutive addresses from reset_pc
localparam int prog_len = 26;
localparam riscv_pkg::word_t prog [prog_len] = '{
    32'h0050_0093, // addi x1, x0, 5
    32'h0030_8113, // addi x2, x1, 3
    32'h0020_81b3, // add  x3, x1, x2
    32'h4011_8233, // sub  x4, x3, x1
    32'h0022_1293, // slli x5, x4, 2
    32'h0032_c333, // xor  x6, x5, x3
    32'h1234_53b7, // lui  x7, 0x12345
    32'h0063_e3b3, // or   x7, x7, x6
    32'h0032_2433, // slt  x8, x4, x3
    32'h1070_2023, // sw   x7, 0x100(x0)
    32'h1080_2223, // sw   x8, 0x104(x0)
    32'h0041_0663, // beq  x2, x4, +12
    32'h1e10_2823, // sw   x1, 0x1f0(x0)
    32'h1e10_2a23, // sw   x1, 0x1f4(x0)
    32'h0041_1463, // bne  x2, x4, +8
    32'h1030_2423, // sw   x3, 0x108(x0)
    32'h00c0_04ef, // jal  x9, +12
    32'h1e10_2c23, // sw   x1, 0x1f8(x0)
    32'h1e10_2e23, // sw   x1, 0x1fc(x0)
    32'h1090_2623, // sw   x9, 0x10c(x0)
    32'h0800_2503, // lw   x10, 0x80(x0)
    32'h0075_0593, // addi x11, x10, 7
    32'h10b0_2823, // sw   x11, 0x110(x0)
    32'h0090_0013, // addi x0, x0, 9
    32'h1000_2a23, // sw   x0, 0x114(x0)
    32'h3e20_2e23  // sw   x2, 0x3fc(x0)
};

// longest program the run allows for
localparam int max_prog_len = 40;

// expected store addresses and data in program order
localparam int store_count = 7;
localparam riscv_pkg::word_t store_addr_list [store_count] = '{
    32'h0000_0100, 32'h0000_0104, 32'h0000_0108, 32'h0000_010c,
    32'h0000_0110, 32'h0000_0114, 32'h0000_03fc
};
// 0x3c5a_0087 is the fill word at 0x80 plus 7
localparam riscv_pkg::word_t store_data_list [store_count] = '{
    32'h1234_502d, 32'h0000_0001, 32'h0000_000d, 32'h0000_0044,
    32'h3c5a_0087, 32'h0000_0000, 32'h0000_0008
};

// stores behind the taken beq and the jal
localparam int skip_count = 4;
localparam riscv_pkg::word_t skip_addr_list [skip_count] = '{
    32'h0000_01f0, 32'h0000_01f4, 32'h0000_01f8, 32'h0000_01fc
};

localparam riscv_pkg::word_t end_addr = 32'h0000_03fc;

`endif

// File: verif/tb_riscv_core.sv
`timescale 1ns/1ps

module tb_riscv_core;

    logic clk;
    logic rst;
    riscv_pkg::word_t inst_addr;
    riscv_pkg::word_t inst_data;
    riscv_pkg::word_t mem_addr;
    riscv_pkg::word_t wdata;
    logic read_en;
    logic write_en;
    riscv_pkg::word_t rdata;
    logic mem_ready;

    `include "tb_program.svh"

    localparam int cycle_limit = max_prog_len * 6;

    riscv_pkg::word_t rom [64];
    riscv_pkg::word_t dmem [256];
    logic [31:0] lfsr;
    int wait_left;
    logic end_seen;
    int store_idx = 0;
    int cycle_count = 0;
    riscv_pkg::word_t exp_addr;
    riscv_pkg::word_t exp_data;
    riscv_pkg::word_t prev_addr;
    riscv_pkg::word_t prev_wdata;
    logic [1:0] prev_en;

    riscv_core i_riscv_core (
        .clk(clk), .rst(rst), .inst_addr(inst_addr), .inst_data(inst_data),
        .mem_addr(mem_addr), .wdata(wdata), .read_en(read_en), .write_en(write_en),
        .rdata(rdata), .mem_ready(mem_ready)
    );

    task automatic stop_run();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(string name, riscv_pkg::word_t expected,
                                   riscv_pkg::word_t actual);
        $display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
        stop_run();
    endtask

    task automatic report_problem(string why);
        $display("%s at %0t", why, $time);
        stop_run();
    endtask

    // taps 32, 22, 2, 1
    function automatic logic next_random_bit();
        lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
        return lfsr[0];
    endfunction

    function automatic int ready_delay();
        logic [1:0] d;
        d[1] = next_random_bit();
        d[0] = next_random_bit();
        return int'(d);
    endfunction

    function automatic logic is_skipped(riscv_pkg::word_t addr);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < skip_count; i++) begin
            if (addr == skip_addr_list[i]) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    assign exp_addr = (store_idx < store_count) ? store_addr_list[store_idx] : '0;
    assign exp_data = (store_idx < store_count) ? store_data_list[store_idx] : '0;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        prev_addr <= mem_addr;
        prev_wdata <= wdata;
        prev_en <= {read_en, write_en};
        if (rst && write_en && mem_ready) begin
            store_idx <= store_idx + 1;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            report_problem($sformatf("program did not finish within %0d cycles", cycle_limit));
        end
    end

    a_reset_pc: assert property (@(posedge clk) $rose(rst) |-> inst_addr == riscv_pkg::reset_pc)
        else report_mismatch("inst_addr", riscv_pkg::reset_pc, $sampled(inst_addr));
    a_reset_en: assert property (@(posedge clk) $rose(rst) |-> !read_en && !write_en)
        else report_mismatch("read_en/write_en", '0, {30'd0, $sampled(read_en), $sampled(write_en)});

    a_store_addr: assert property (@(posedge clk) disable iff (!rst)
        write_en && mem_ready |-> mem_addr == exp_addr)
        else report_mismatch("mem_addr", $sampled(exp_addr), $sampled(mem_addr));
    a_store_data: assert property (@(posedge clk) disable iff (!rst)
        write_en && mem_ready |-> wdata == exp_data)
        else report_mismatch("wdata", $sampled(exp_data), $sampled(wdata));

    a_no_skipped: assert property (@(posedge clk) disable iff (!rst)
        (read_en || write_en) |-> !is_skipped(mem_addr))
        else report_problem("a store behind a taken branch or jal reached the data port");

    // request must hold until mem_ready
    a_addr_held: assert property (@(posedge clk) disable iff (!rst)
        (read_en || write_en) && !mem_ready |=> mem_addr == prev_addr)
        else report_mismatch("mem_addr", $sampled(prev_addr), $sampled(mem_addr));
    a_wdata_held: assert property (@(posedge clk) disable iff (!rst)
        (read_en || write_en) && !mem_ready |=> wdata == prev_wdata)
        else report_mismatch("wdata", $sampled(prev_wdata), $sampled(wdata));
    a_en_held: assert property (@(posedge clk) disable iff (!rst)
        (read_en || write_en) && !mem_ready |=> {read_en, write_en} == prev_en)
        else report_mismatch("read_en/write_en", {30'd0, $sampled(prev_en)},
                             {30'd0, $sampled(read_en), $sampled(write_en)});

    initial begin
        rst = 1'b0;
        mem_ready = 1'b0;
        rdata = '0;
        lfsr = 32'h9e99;
        wait_left = -1;
        end_seen = 1'b0;
        for (int i = 0; i < 64; i++) begin
            rom[i] = (i < prog_len) ? prog[i] : '0;
        end
        // fill from the byte address
        for (int i = 0; i < 256; i++) begin
            dmem[i] = (i * 4) ^ 32'h3c5a_0000;
        end
        inst_data = rom[0];
        repeat (3) @(posedge clk);
        #5 rst = 1'b1;
        while (!end_seen) begin
            @(posedge clk);
            #5;
            inst_data = rom[inst_addr[7:2]];
            if (mem_ready) begin
                wait_left = -1;
            end
            mem_ready = 1'b0;
            if (read_en || write_en) begin
                if (wait_left < 0) begin
                    wait_left = ready_delay();
                end
                if (wait_left == 0) begin
                    mem_ready = 1'b1;
                    if (write_en) begin
                        dmem[mem_addr[9:2]] = wdata;
                        if (mem_addr == end_addr) begin
                            end_seen = 1'b1;
                        end
                    end else begin
                        rdata = dmem[mem_addr[9:2]];
                    end
                end else begin
                    wait_left = wait_left - 1;
                end
            end
        end
        // let the end store pass its checks
        @(posedge clk);
        #5;
        $display("Simulation passed");
        $finish;
    end

endmodule
